//--- Bender.yml
package:
  name: phy_status

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - phy_cal_pkg.sv
      - phy_csr_pkg.sv
      - phy_csr_front.sv
      - phy_cal_sequencer.sv
      - phy_csr_regs.sv
      - phy_status_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_phy_status.sv

//--- phy_cal_pkg.sv
// calibration sequencer state and stage-code types, referenced by scoped name
package phy_cal_pkg;

	// sequencer states
	// IDLE is left once, on the first lock after reset
	// WAIT_LOCK clears the run and holds until the PLL is locked
	// SWEEP walks the taps of one group, CHECK_GROUP judges that group
	typedef enum logic [2:0] {
		IDLE,
		WAIT_LOCK,
		SWEEP,
		CHECK_GROUP,
		DONE_OK,
		DONE_FAIL
	} phy_cal_state_e;

	// stage code reported in the failure-location register
	// only the read-window stage exists in this PHY
	typedef enum logic [7:0] {
		// no failure recorded
		STAGE_NONE = 8'd0,
		// the read capture window of a DQS group was too narrow
		STAGE_READ_WINDOW = 8'd1
	} phy_cal_stage_e;

endpackage

//--- phy_cal_sequencer.sv
// read-window calibration FSM that sweeps every tap of every DQS group and reports the result
`timescale 1ns/100ps
`include "phy_consts.svh"

module phy_cal_sequencer (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          pll_locked,
	input  logic                          recal_req,
	input  logic                          tap_pass,
	output logic [`PHY_TAP_WIDTH-1:0]     tap_select,
	output logic [`PHY_GROUP_WIDTH-1:0]   group_select,
	output logic                          cal_success,
	output logic                          cal_fail,
	output logic [7:0]                    seq_fom_in,
	output logic [7:0]                    seq_fom_out,
	output logic [7:0]                    cal_fail_stage,
	output logic [7:0]                    cal_fail_substage,
	output logic [7:0]                    cal_fail_group
);

	localparam logic [`PHY_TAP_WIDTH-1:0] TAP_LAST = `PHY_TAP_WIDTH'(`PHY_NUM_TAPS - 1);
	localparam logic [`PHY_GROUP_WIDTH-1:0] GROUP_LAST =
		`PHY_GROUP_WIDTH'(`PHY_NUM_GROUPS - 1);
	localparam logic [7:0] MIN_PASS = 8'(`PHY_CAL_MIN_PASS);

	phy_cal_pkg::phy_cal_state_e state;
	phy_cal_pkg::phy_cal_stage_e fail_stage;
	logic [`PHY_TAP_WIDTH-1:0] tap_cnt;
	logic [`PHY_GROUP_WIDTH-1:0] group_cnt;
	// passing taps seen so far in the current group
	logic [7:0] pass_cnt;
	logic [7:0] fom_min;
	logic [7:0] fom_sum;
	logic [7:0] fail_substage;
	logic [7:0] fail_group;

	// the eye is probed at the current counters
	// tap_pass comes back in the same cycle
	assign tap_select = tap_cnt;
	assign group_select = group_cnt;

	// done flags decode straight from the state so they are never high together
	assign cal_success = (state == phy_cal_pkg::DONE_OK);
	assign cal_fail = (state == phy_cal_pkg::DONE_FAIL);

	assign seq_fom_in = fom_min;
	assign seq_fom_out = fom_sum;
	assign cal_fail_stage = fail_stage;
	assign cal_fail_substage = fail_substage;
	assign cal_fail_group = fail_group;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= phy_cal_pkg::IDLE;
			tap_cnt <= '0;
			group_cnt <= '0;
			pass_cnt <= '0;
			fom_min <= '0;
			fom_sum <= '0;
			fail_stage <= phy_cal_pkg::STAGE_NONE;
			fail_substage <= '0;
			fail_group <= '0;
		end else begin
			case (state)
				// nothing has run yet and the first lock starts calibration
				phy_cal_pkg::IDLE: begin
					if (pll_locked)
						state <= phy_cal_pkg::WAIT_LOCK;
				end
				// every run starts here with clean counters and results
				phy_cal_pkg::WAIT_LOCK: begin
					tap_cnt <= '0;
					group_cnt <= '0;
					pass_cnt <= '0;
					fom_min <= '0;
					fom_sum <= '0;
					fail_stage <= phy_cal_pkg::STAGE_NONE;
					fail_substage <= '0;
					fail_group <= '0;
					if (pll_locked)
						state <= phy_cal_pkg::SWEEP;
				end
				// one tap per cycle until the last tap hands over to the group check
				phy_cal_pkg::SWEEP: begin
					if (tap_pass)
						pass_cnt <= pass_cnt + 8'd1;
					if (tap_cnt == TAP_LAST) begin
						tap_cnt <= '0;
						state <= phy_cal_pkg::CHECK_GROUP;
					end else begin
						tap_cnt <= tap_cnt + 1'b1;
					end
				end
				// pass_cnt now holds the full count of the group just swept
				// the failing group is still folded into the figure of merit
				phy_cal_pkg::CHECK_GROUP: begin
					fom_sum <= fom_sum + pass_cnt;
					if (group_cnt == '0 || pass_cnt < fom_min)
						fom_min <= pass_cnt;
					pass_cnt <= '0;
					if (pass_cnt < MIN_PASS) begin
						fail_stage <= phy_cal_pkg::STAGE_READ_WINDOW;
						fail_substage <= pass_cnt;
						fail_group <= 8'(group_cnt);
						state <= phy_cal_pkg::DONE_FAIL;
					end else if (group_cnt == GROUP_LAST) begin
						state <= phy_cal_pkg::DONE_OK;
					end else begin
						group_cnt <= group_cnt + 1'b1;
						state <= phy_cal_pkg::SWEEP;
					end
				end
				// results hold until software asks for another run
				phy_cal_pkg::DONE_OK,
				phy_cal_pkg::DONE_FAIL: begin
					if (recal_req)
						state <= phy_cal_pkg::WAIT_LOCK;
				end
				default: state <= phy_cal_pkg::IDLE;
			endcase
		end
	end

	// success is only reported once the last group was judged and leaves the failure fields clean
	a_ok_result : assert property (
		@(posedge clk) disable iff (!reset_n)
		cal_success |-> group_select == GROUP_LAST
			&& cal_fail_stage == phy_cal_pkg::STAGE_NONE
			&& cal_fail_substage == 8'd0 && cal_fail_group == 8'd0
	);

	// a failure names a too narrow read window in the group where the sweep stopped
	a_fail_result : assert property (
		@(posedge clk) disable iff (!reset_n)
		cal_fail |-> cal_fail_stage == phy_cal_pkg::STAGE_READ_WINDOW
			&& cal_fail_substage < MIN_PASS
			&& cal_fail_group == 8'(group_select)
	);

endmodule

//--- phy_consts.svh
// widths, counts and fixed register values shared by the PHY status RTL, pulled in by `include
`ifndef PHY_CONSTS_SVH
`define PHY_CONSTS_SVH

// register port geometry, one 32-bit word per address
`define PHY_CSR_ADDR_WIDTH 8
`define PHY_CSR_DATA_WIDTH 32
`define PHY_CSR_BE_WIDTH 4

// calibration geometry
// group and tap widths must cover the counts below
`define PHY_NUM_GROUPS 4
`define PHY_NUM_TAPS 8
`define PHY_TAP_WIDTH 3
`define PHY_GROUP_WIDTH 2

// a group with fewer passing taps than this has too narrow a read window
`define PHY_CAL_MIN_PASS 3

// identification words, the low half of the version register is fixed at 4
`define PHY_CSR_SIGNATURE 32'hdeadbeef
`define PHY_CSR_VERSION 16'd201

// mode-register image reported to software
// RTT_NOM and drive strength go to MR1, dynamic ODT goes to MR2
`define PHY_MR1_RTT 3'b010
`define PHY_MR1_ODS 2'b01
`define PHY_MR2_RTT_WR 2'b10

`endif

//--- phy_csr_front.sv
// request side of the PHY register port that registers each strobe and decodes the word address
`timescale 1ns/100ps
`include "phy_consts.svh"

module phy_csr_front (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic [`PHY_CSR_ADDR_WIDTH-1:0]   csr_addr,
	input  logic [`PHY_CSR_BE_WIDTH-1:0]     csr_be,
	input  logic                             csr_write_req,
	input  logic [`PHY_CSR_DATA_WIDTH-1:0]   csr_wdata,
	input  logic                             csr_read_req,
	output logic                             csr_waitrequest,
	output logic                             req_read,
	output logic                             req_write,
	output phy_csr_pkg::phy_csr_reg_e        req_reg,
	output logic [`PHY_CSR_DATA_WIDTH-1:0]   req_wdata,
	output logic [`PHY_CSR_BE_WIDTH-1:0]     req_be
);

	phy_csr_pkg::phy_csr_reg_e addr_reg;

	// map the raw address onto the register index
	// holes in the map fall through to REG_NONE
	always_comb begin
		case (csr_addr)
			8'h01: addr_reg = phy_csr_pkg::REG_SIGNATURE;
			8'h02: addr_reg = phy_csr_pkg::REG_VERSION;
			8'h04: addr_reg = phy_csr_pkg::REG_CAL_STATUS;
			8'h05: addr_reg = phy_csr_pkg::REG_FOM;
			8'h06: addr_reg = phy_csr_pkg::REG_FAIL_LOC;
			8'h07: addr_reg = phy_csr_pkg::REG_CONTROL;
			8'h08: addr_reg = phy_csr_pkg::REG_MODE;
			default: addr_reg = phy_csr_pkg::REG_NONE;
		endcase
	end

	// waitrequest sits high through reset and drops at the first edge after it
	// strobes are only taken once the port is open
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			csr_waitrequest <= 1'b1;
			req_read <= 1'b0;
			req_write <= 1'b0;
		end else begin
			csr_waitrequest <= 1'b0;
			req_read <= csr_read_req & ~csr_waitrequest;
			req_write <= csr_write_req & ~csr_waitrequest;
		end
	end

	// address, data and byte enables ride along with the pulses
	// they are only looked at while a pulse is high
	always_ff @(posedge clk) begin
		req_reg <= addr_reg;
		req_wdata <= csr_wdata;
		req_be <= csr_be;
	end

	// a strobe offered while the port is still closed would be dropped
	a_no_accept_in_wait : assert property (
		@(posedge clk) disable iff (!reset_n)
		(csr_read_req || csr_write_req) |-> !csr_waitrequest
	);

endmodule

//--- phy_csr_pkg.sv
// register map types for the PHY status port, referenced by scoped name from the CSR blocks
`include "phy_consts.svh"

package phy_csr_pkg;

	// register index, the value equals the word address on the bus
	// the front end maps every unlisted address onto REG_NONE
	typedef enum logic [`PHY_CSR_ADDR_WIDTH-1:0] {
		// reads as zero and ignores writes
		REG_NONE = 8'h00,
		// fixed identification word
		REG_SIGNATURE = 8'h01,
		// IP version in the upper half
		REG_VERSION = 8'h02,
		// success, fail and started flags in bits 26:24
		REG_CAL_STATUS = 8'h04,
		// figure of merit for the read window
		REG_FOM = 8'h05,
		// stage, substage and group of the first failure
		REG_FAIL_LOC = 8'h06,
		// recalibrate strobe and scratch byte
		REG_CONTROL = 8'h07,
		// mode-register image
		REG_MODE = 8'h08
	} phy_csr_reg_e;

endpackage

//--- phy_csr_regs.sv
// register side of the PHY port, status snapshot, control register and read response
`timescale 1ns/100ps
`include "phy_consts.svh"

module phy_csr_regs (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic                             req_read,
	input  logic                             req_write,
	input  phy_csr_pkg::phy_csr_reg_e        req_reg,
	input  logic [`PHY_CSR_DATA_WIDTH-1:0]   req_wdata,
	input  logic [`PHY_CSR_BE_WIDTH-1:0]     req_be,
	input  logic                             cal_success,
	input  logic                             cal_fail,
	input  logic [7:0]                       seq_fom_in,
	input  logic [7:0]                       seq_fom_out,
	input  logic [7:0]                       cal_fail_stage,
	input  logic [7:0]                       cal_fail_substage,
	input  logic [7:0]                       cal_fail_group,
	output logic                             recal_req,
	output logic [`PHY_CSR_DATA_WIDTH-1:0]   csr_rdata,
	output logic                             csr_rdata_valid
);

	// first stage of the read and write pipelines
	logic rd_pend;
	phy_csr_pkg::phy_csr_reg_e rd_reg;
	logic wr_pend;
	phy_csr_pkg::phy_csr_reg_e wr_reg;
	logic [`PHY_CSR_DATA_WIDTH-1:0] wr_data;
	logic [`PHY_CSR_BE_WIDTH-1:0] wr_be;

	// status copy, refreshed every cycle
	logic snap_success;
	logic snap_fail;
	logic snap_started;
	logic [7:0] snap_fom_in;
	logic [7:0] snap_fom_out;
	logic [7:0] snap_stage;
	logic [7:0] snap_substage;
	logic [7:0] snap_group;

	logic [7:0] scratch;
	logic [`PHY_CSR_DATA_WIDTH-1:0] rd_word;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_pend <= 1'b0;
			wr_pend <= 1'b0;
		end else begin
			rd_pend <= req_read;
			wr_pend <= req_write;
		end
	end

	always_ff @(posedge clk) begin
		rd_reg <= req_reg;
		wr_reg <= req_reg;
		wr_data <= req_wdata;
		wr_be <= req_be;
	end

	// the started flag goes up with the first result and stays up
	// a result can only appear once the sequencer has left IDLE
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			snap_success <= 1'b0;
			snap_fail <= 1'b0;
			snap_started <= 1'b0;
			snap_fom_in <= '0;
			snap_fom_out <= '0;
			snap_stage <= '0;
			snap_substage <= '0;
			snap_group <= '0;
		end else begin
			snap_success <= cal_success;
			snap_fail <= cal_fail;
			snap_started <= snap_started | cal_success | cal_fail;
			snap_fom_in <= seq_fom_in;
			snap_fom_out <= seq_fom_out;
			snap_stage <= cal_fail_stage;
			snap_substage <= cal_fail_substage;
			snap_group <= cal_fail_group;
		end
	end

	// captured writes land one edge after capture
	// bit 0 of the control word is a strobe and is never stored
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			scratch <= '0;
			recal_req <= 1'b0;
		end else begin
			recal_req <= 1'b0;
			if (wr_pend && wr_reg == phy_csr_pkg::REG_CONTROL) begin
				if (wr_be[1])
					scratch <= wr_data[15:8];
				recal_req <= wr_be[0] & wr_data[0];
			end
		end
	end

	// read mux, evaluated at the second stage so it sees writes captured one cycle earlier
	always_comb begin
		case (rd_reg)
			phy_csr_pkg::REG_SIGNATURE:
				rd_word = `PHY_CSR_SIGNATURE;
			phy_csr_pkg::REG_VERSION:
				rd_word = {`PHY_CSR_VERSION, 16'h0004};
			phy_csr_pkg::REG_CAL_STATUS:
				rd_word = {5'b0, snap_started, snap_fail, snap_success, 24'b0};
			phy_csr_pkg::REG_FOM:
				rd_word = {8'b0, snap_fom_out, 8'b0, snap_fom_in};
			phy_csr_pkg::REG_FAIL_LOC:
				rd_word = {8'b0, snap_group, snap_substage, snap_stage};
			phy_csr_pkg::REG_CONTROL:
				rd_word = {16'b0, scratch, 8'b0};
			// MR1 fields sit in 2:0 and 6:5, the MR2 field in 10:9
			phy_csr_pkg::REG_MODE:
				rd_word = {21'b0, `PHY_MR2_RTT_WR, 2'b0, `PHY_MR1_ODS, 2'b0, `PHY_MR1_RTT};
			default:
				rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			csr_rdata <= '0;
			csr_rdata_valid <= 1'b0;
		end else begin
			csr_rdata_valid <= rd_pend;
			if (rd_pend)
				csr_rdata <= rd_word;
		end
	end

	// every response belongs to a request taken two edges before it
	a_rdata_latency : assert property (
		@(posedge clk) disable iff (!reset_n)
		csr_rdata_valid |-> $past(req_read, 2)
	);

endmodule

//--- phy_status_top.sv
// PHY status and calibration-report subsystem, wires the register port to the sequencer
`timescale 1ns/100ps
`include "phy_consts.svh"

module phy_status_top (
	input  logic                             clk,
	input  logic                             reset_n,
	input  logic [`PHY_CSR_ADDR_WIDTH-1:0]   csr_addr,
	input  logic [`PHY_CSR_BE_WIDTH-1:0]     csr_be,
	input  logic                             csr_write_req,
	input  logic [`PHY_CSR_DATA_WIDTH-1:0]   csr_wdata,
	input  logic                             csr_read_req,
	output logic [`PHY_CSR_DATA_WIDTH-1:0]   csr_rdata,
	output logic                             csr_rdata_valid,
	output logic                             csr_waitrequest,
	input  logic                             pll_locked,
	input  logic                             tap_pass,
	output logic [`PHY_TAP_WIDTH-1:0]        tap_select,
	output logic [`PHY_GROUP_WIDTH-1:0]      group_select
);

	// decoded request from the front end
	logic req_read;
	logic req_write;
	phy_csr_pkg::phy_csr_reg_e req_reg;
	logic [`PHY_CSR_DATA_WIDTH-1:0] req_wdata;
	logic [`PHY_CSR_BE_WIDTH-1:0] req_be;

	// sequencer results and the recalibrate strobe going back
	logic cal_success;
	logic cal_fail;
	logic [7:0] seq_fom_in;
	logic [7:0] seq_fom_out;
	logic [7:0] cal_fail_stage;
	logic [7:0] cal_fail_substage;
	logic [7:0] cal_fail_group;
	logic recal_req;

	phy_csr_front u_front (
		.clk             (clk),
		.reset_n         (reset_n),
		.csr_addr        (csr_addr),
		.csr_be          (csr_be),
		.csr_write_req   (csr_write_req),
		.csr_wdata       (csr_wdata),
		.csr_read_req    (csr_read_req),
		.csr_waitrequest (csr_waitrequest),
		.req_read        (req_read),
		.req_write       (req_write),
		.req_reg         (req_reg),
		.req_wdata       (req_wdata),
		.req_be          (req_be)
	);

	phy_cal_sequencer u_seq (
		.clk               (clk),
		.reset_n           (reset_n),
		.pll_locked        (pll_locked),
		.recal_req         (recal_req),
		.tap_pass          (tap_pass),
		.tap_select        (tap_select),
		.group_select      (group_select),
		.cal_success       (cal_success),
		.cal_fail          (cal_fail),
		.seq_fom_in        (seq_fom_in),
		.seq_fom_out       (seq_fom_out),
		.cal_fail_stage    (cal_fail_stage),
		.cal_fail_substage (cal_fail_substage),
		.cal_fail_group    (cal_fail_group)
	);

	phy_csr_regs u_regs (
		.clk               (clk),
		.reset_n           (reset_n),
		.req_read          (req_read),
		.req_write         (req_write),
		.req_reg           (req_reg),
		.req_wdata         (req_wdata),
		.req_be            (req_be),
		.cal_success       (cal_success),
		.cal_fail          (cal_fail),
		.seq_fom_in        (seq_fom_in),
		.seq_fom_out       (seq_fom_out),
		.cal_fail_stage    (cal_fail_stage),
		.cal_fail_substage (cal_fail_substage),
		.cal_fail_group    (cal_fail_group),
		.recal_req         (recal_req),
		.csr_rdata         (csr_rdata),
		.csr_rdata_valid   (csr_rdata_valid)
	);

endmodule

//--- sources.f
+incdir+.
phy_cal_pkg.sv
phy_csr_pkg.sv
phy_csr_front.sv
phy_cal_sequencer.sv
phy_csr_regs.sv
phy_status_top.sv
tb_phy_status.sv

//--- tb_phy_status.sv
// self-checking testbench that runs the PHY status subsystem against an eye and register model
`timescale 1ns/100ps
`include "phy_consts.svh"

module tb_phy_status;

	// up to 20 calibrations bounded by the sweep length plus the register traffic
	localparam int CYCLE_LIMIT = 20 * (4 * 10 + 4) + 2000;

	logic clk;
	logic reset_n;
	logic [`PHY_CSR_ADDR_WIDTH-1:0] csr_addr;
	logic [`PHY_CSR_BE_WIDTH-1:0] csr_be;
	logic csr_write_req;
	logic [`PHY_CSR_DATA_WIDTH-1:0] csr_wdata;
	logic csr_read_req;
	logic [`PHY_CSR_DATA_WIDTH-1:0] csr_rdata;
	logic csr_rdata_valid;
	logic csr_waitrequest;
	logic pll_locked;
	logic tap_pass;
	logic [`PHY_TAP_WIDTH-1:0] tap_select;
	logic [`PHY_GROUP_WIDTH-1:0] group_select;

	// bit group*taps+tap of the eye model is high when that tap captures cleanly
	logic [31:0] eye_mask;

	// probe position seen at the previous falling edge
	logic [`PHY_TAP_WIDTH-1:0] prev_tap;
	logic [`PHY_GROUP_WIDTH-1:0] prev_group;

	// register and calibration model
	logic [7:0] scratch_model;
	logic m_success;
	logic m_fail;
	logic m_started;
	logic [7:0] m_fom_in;
	logic [7:0] m_fom_out;
	logic [7:0] m_stage;
	logic [7:0] m_substage;
	logic [7:0] m_group;

	// one entry per outstanding read with the oldest first
	logic [7:0] addr_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] care_q[$];
	int due_q[$];

	logic [31:0] last_rdata;
	int cycle;
	int checks;
	int errors;
	int ok_runs;
	int fail_runs;

	phy_status_top UUT (
		.clk             (clk),
		.reset_n         (reset_n),
		.csr_addr        (csr_addr),
		.csr_be          (csr_be),
		.csr_write_req   (csr_write_req),
		.csr_wdata       (csr_wdata),
		.csr_read_req    (csr_read_req),
		.csr_rdata       (csr_rdata),
		.csr_rdata_valid (csr_rdata_valid),
		.csr_waitrequest (csr_waitrequest),
		.pll_locked      (pll_locked),
		.tap_pass        (tap_pass),
		.tap_select      (tap_select),
		.group_select    (group_select)
	);

	// the eye answers in the same cycle as the probe
	assign tap_pass = eye_mask[{group_select, tap_select}];

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a read response or calibration never came",
				cycle);
			$display("Verification failed");
			$finish;
		end
	end

	// the probe walks the taps of a group in order before it moves to the next group
	// a new run starts over at tap 0 of group 0
	always @(negedge clk) begin : probe_check
		logic step_tap;
		logic step_group;
		logic restart;
		step_tap = (tap_select == prev_tap + 1'b1) && (group_select == prev_group);
		step_group = (tap_select == '0) && (prev_tap == '0)
			&& (group_select == prev_group + 1'b1);
		restart = (tap_select == '0) && (group_select == '0);
		if (reset_n && {group_select, tap_select} != {prev_group, prev_tap}
			&& !(step_tap || step_group || restart)) begin
			$display("probe jumped from group %0d tap %0d to group %0d tap %0d out of order",
				prev_group, prev_tap, group_select, tap_select);
			errors++;
		end
		prev_tap = tap_select;
		prev_group = group_select;
	end

	// responses are taken at the falling edge where the registered outputs have settled
	always @(negedge clk) begin : rsp_check
		logic [7:0] addr;
		logic [31:0] exp;
		logic [31:0] care;
		int due;
		if (csr_rdata_valid) begin
			if (exp_q.size() == 0) begin
				$display("read response arrived while no read was outstanding");
				errors++;
			end else begin
				addr = addr_q.pop_front();
				exp = exp_q.pop_front();
				care = care_q.pop_front();
				due = due_q.pop_front();
				checks++;
				if (cycle != due) begin
					$display("read of address %h answered in cycle %0d instead of %0d",
						addr, cycle, due);
					errors++;
				end
				if ((csr_rdata & care) !== (exp & care)) begin
					$display("CHECK FAILED csr_rdata at address %h: got %h expected %h",
						addr, csr_rdata & care, exp & care);
					errors++;
				end
				last_rdata = csr_rdata;
			end
		end
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// read data as the register table describes it and built from the model state
	function automatic logic [31:0] expect_word(input logic [7:0] addr);
		logic [31:0] w;
		w = 32'h0;
		case (addr)
			8'h01: w = `PHY_CSR_SIGNATURE;
			8'h02: w = {`PHY_CSR_VERSION, 16'd4};
			8'h04: w = {5'b0, m_started, m_fail, m_success, 24'b0};
			8'h05: w = {8'b0, m_fom_out, 8'b0, m_fom_in};
			8'h06: w = {8'b0, m_group, m_substage, m_stage};
			8'h07: w = {16'b0, scratch_model, 8'b0};
			8'h08: w = (32'(`PHY_MR2_RTT_WR) << 9) | (32'(`PHY_MR1_ODS) << 5)
				| 32'(`PHY_MR1_RTT);
			default: w = 32'h0;
		endcase
		return w;
	endfunction

	// groups are judged in order and the first narrow window ends the run
	task automatic model_calibration(input logic [31:0] mask);
		int count;
		int sum;
		int lowest;
		sum = 0;
		lowest = 0;
		m_success = 1'b1;
		m_fail = 1'b0;
		m_stage = 8'h0;
		m_substage = 8'h0;
		m_group = 8'h0;
		for (int g = 0; g < `PHY_NUM_GROUPS; g++) begin
			count = 0;
			for (int t = 0; t < `PHY_NUM_TAPS; t++)
				count += mask[g * `PHY_NUM_TAPS + t];
			sum += count;
			if (g == 0 || count < lowest)
				lowest = count;
			if (count < `PHY_CAL_MIN_PASS) begin
				m_success = 1'b0;
				m_fail = 1'b1;
				m_stage = 8'(phy_cal_pkg::STAGE_READ_WINDOW);
				m_substage = 8'(count);
				m_group = 8'(g);
				break;
			end
		end
		m_fom_in = 8'(lowest);
		m_fom_out = 8'(sum);
		m_started = 1'b1;
	endtask

	task automatic set_mask(input logic [31:0] mask);
		@(posedge clk);
		#1;
		eye_mask = mask;
		model_calibration(mask);
	endtask

	// care selects the bits compared and zero means the data is only collected
	task automatic issue_read(input logic [7:0] addr, input logic [31:0] care);
		@(posedge clk);
		#1;
		csr_addr = addr;
		csr_read_req = 1'b1;
		csr_write_req = 1'b0;
		addr_q.push_back(addr);
		exp_q.push_back(expect_word(addr));
		care_q.push_back(care);
		due_q.push_back(cycle + 3);
	endtask

	task automatic issue_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		@(posedge clk);
		#1;
		csr_addr = addr;
		csr_wdata = data;
		csr_be = be;
		csr_write_req = 1'b1;
		csr_read_req = 1'b0;
		if (addr == 8'h07 && be[1])
			scratch_model = data[15:8];
	endtask

	task automatic bus_idle();
		@(posedge clk);
		#1;
		csr_read_req = 1'b0;
		csr_write_req = 1'b0;
	endtask

	task automatic read_word(input logic [7:0] addr, input logic [31:0] care);
		issue_read(addr, care);
		bus_idle();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	// polls the status word until the previous result has cleared
	task automatic wait_cal_start();
		last_rdata = 32'h03000000;
		while (last_rdata[25:24] != 2'b00)
			read_word(8'h04, 32'h0);
	endtask

	// polls the status word until success or fail shows
	task automatic wait_cal_done();
		last_rdata = 32'h0;
		while (last_rdata[25:24] == 2'b00)
			read_word(8'h04, 32'h0);
	endtask

	task automatic check_cal_regs();
		read_word(8'h04, 32'h07000000);
		read_word(8'h05, 32'h00ff00ff);
		read_word(8'h06, 32'h00ffffff);
		if (m_success)
			ok_runs++;
		else
			fail_runs++;
	endtask

	task automatic report_test(input int num, input string title, input int mark);
		$display("test %0d %s finished with %0d errors", num, title, errors - mark);
	endtask

	initial begin
		int seed_ret;
		int mark;
		logic [7:0] a;
		logic [31:0] d;
		logic [3:0] be;
		clk = 1'b0;
		reset_n = 1'b0;
		csr_addr = '0;
		csr_be = '0;
		csr_write_req = 1'b0;
		csr_wdata = '0;
		csr_read_req = 1'b0;
		pll_locked = 1'b0;
		eye_mask = 32'h0;
		prev_tap = '0;
		prev_group = '0;
		scratch_model = 8'h0;
		m_success = 1'b0;
		m_fail = 1'b0;
		m_started = 1'b0;
		m_fom_in = 8'h0;
		m_fom_out = 8'h0;
		m_stage = 8'h0;
		m_substage = 8'h0;
		m_group = 8'h0;
		last_rdata = 32'h0;
		cycle = 0;
		checks = 0;
		errors = 0;
		ok_runs = 0;
		fail_runs = 0;
		seed_ret = $urandom(32'he3d0cbb7);

		// reset holds the port closed and silent
		mark = errors;
		repeat (4) begin
			@(negedge clk);
			check_val("csr_waitrequest", 32'(csr_waitrequest), 32'h1);
			check_val("csr_rdata_valid", 32'(csr_rdata_valid), 32'h0);
		end
		@(posedge clk);
		#1;
		reset_n = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_val("csr_waitrequest", 32'(csr_waitrequest), 32'h0);
		read_word(8'h04, 32'hffffffff);
		report_test(1, "reset and idle status", mark);

		mark = errors;
		read_word(8'h01, 32'hffffffff);
		read_word(8'h02, 32'hffffffff);
		read_word(8'h08, 32'hffffffff);
		for (int i = 0; i < 6; i++) begin
			a = 8'($urandom);
			while (a inside {8'h01, 8'h02, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08})
				a = 8'($urandom);
			read_word(a, 32'hffffffff);
		end
		report_test(2, "fixed registers and unmapped addresses", mark);

		// first calibration starts on lock
		mark = errors;
		set_mask($urandom);
		@(posedge clk);
		#1;
		pll_locked = 1'b1;
		wait_cal_done();
		check_cal_regs();
		report_test(3, "first calibration", mark);

		mark = errors;
		for (int i = 0; i < 12; i++) begin
			d = $urandom & 32'hfffffffe;
			be = 4'($urandom);
			issue_write(8'h07, d, be);
			read_word(8'h07, 32'hffffffff);
		end
		report_test(4, "control scratch byte", mark);

		// even rounds carry three passing taps in every group while odd rounds get a thin eye
		mark = errors;
		for (int r = 0; r < 10; r++) begin
			if (r % 2 == 0)
				set_mask($urandom | 32'h1c1c1c1c);
			else
				set_mask($urandom & $urandom);
			d = $urandom | 32'h1;
			be = 4'($urandom) | 4'h1;
			issue_write(8'h07, d, be);
			bus_idle();
			// the old result has to leave the status copy before the new run is awaited
			wait_cal_start();
			wait_cal_done();
			check_cal_regs();
			read_word(8'h07, 32'hffffffff);
		end
		if (ok_runs == 0 || fail_runs == 0) begin
			$display("calibrations gave %0d successes and %0d failures, both kinds were expected",
				ok_runs, fail_runs);
			errors++;
		end
		report_test(5, "recalibration rounds", mark);

		mark = errors;
		for (int i = 0; i < 24; i++)
			issue_read(8'($urandom % 12), 32'hffffffff);
		bus_idle();
		while (exp_q.size() != 0)
			@(posedge clk);
		report_test(6, "back-to-back reads", mark);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
